/* all.f */
+incdir+source
+incdir+testbench
source/idPkg.sv
source/instDecoder.sv
source/operandSelect.sv
source/branchUnit.sv
source/idExReg.sv
source/idStage.sv
testbench/idStageTb.sv

/* Makefile */
TOP := idStageTb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* testbench/idStageChecks.svh */
`ifndef ID_STAGE_CHECKS_SVH
`define ID_STAGE_CHECKS_SVH

int    errorCount = 0;
int    passCount  = 0;
int    failCount  = 0;
string testName   = "reset";

task automatic checkWord(
    input string              what,
    input logic [`WORD_W-1:0] got,
    input logic [`WORD_W-1:0] exp
);
    if (got !== exp)
    begin
        $display("** Error at time %0t: %s, %s is %h, expected %h",
                 $time, testName, what, got, exp);
        errorCount++;
    end
endtask

task automatic checkOp(
    input string            what,
    input logic [`OP_W-1:0] got,
    input logic [`OP_W-1:0] exp
);
    if (got !== exp)
    begin
        $display("** Error at time %0t: %s, %s is %0d, expected %0d",
                 $time, testName, what, got, exp);
        errorCount++;
    end
endtask

task automatic checkAddr(
    input string                  what,
    input logic [`REG_ADDR_W-1:0] got,
    input logic [`REG_ADDR_W-1:0] exp
);
    if (got !== exp)
    begin
        $display("** Error at time %0t: %s, %s is r%0d, expected r%0d",
                 $time, testName, what, got, exp);
        errorCount++;
    end
endtask

task automatic checkBit(
    input string what,
    input logic  got,
    input logic  exp
);
    if (got !== exp)
    begin
        $display("** Error at time %0t: %s, %s is %b, expected %b",
                 $time, testName, what, got, exp);
        errorCount++;
    end
endtask

// one line per finished test
task automatic reportTest(input int errorsBefore);
    if (errorCount == errorsBefore)
    begin
        passCount++;
        $display("%-14s ok", testName);
    end
    else
    begin
        failCount++;
        $display("%-14s FAILED with %0d errors", testName, errorCount - errorsBefore);
    end
endtask

`endif

/* testbench/idStageTb.sv */
`include "id_defs.svh"

module idStageTb;

    localparam int ResetCycles  = 8;
    localparam int ResetTimeout = 4 * ResetCycles;

    localparam logic [`WORD_W-1:0] PcBase = 32'h0040_1000;
    localparam logic [`WORD_W-1:0] PcHigh = 32'hb000_2000; // nonzero top nibble for j
    localparam logic [`WORD_W-1:0] PcEdge = 32'h2fff_fffc; // pc+4 enters next region

    logic                   clk;
    logic                   rstN;
    logic [`WORD_W-1:0]     inst;
    logic [`WORD_W-1:0]     pc;
    logic [`WORD_W-1:0]     rfDataA;
    logic [`WORD_W-1:0]     rfDataB;
    logic                   regaRead;
    logic                   regbRead;
    logic [`REG_ADDR_W-1:0] regaAddr;
    logic [`REG_ADDR_W-1:0] regbAddr;
    logic                   jCe;
    logic [`WORD_W-1:0]     jAddr;
    logic [`OP_W-1:0]       exOp;
    logic [`WORD_W-1:0]     exRegaData;
    logic [`WORD_W-1:0]     exRegbData;
    logic                   exRegcWrite;
    logic [`REG_ADDR_W-1:0] exRegcAddr;

    typedef struct
    {
        string                  name;
        logic [`WORD_W-1:0]     instBits;
        logic [`WORD_W-1:0]     pcVal;
        logic [`WORD_W-1:0]     dataA;
        logic [`WORD_W-1:0]     dataB;
        logic                   aRead;
        logic                   bRead;
        logic [`REG_ADDR_W-1:0] aAddr;
        logic [`REG_ADDR_W-1:0] bAddr;
        logic                   jump;
        logic [`WORD_W-1:0]     target;
        logic [`OP_W-1:0]       op;
        logic [`WORD_W-1:0]     exA;
        logic [`WORD_W-1:0]     exB;
        logic                   cWrite;
        logic [`REG_ADDR_W-1:0] cAddr;
    } tableRow;

    tableRow rows[$];

    `include "idStageChecks.svh"

    idStage i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .inst        (inst),
        .pc          (pc),
        .rfDataA     (rfDataA),
        .rfDataB     (rfDataB),
        .regaRead    (regaRead),
        .regbRead    (regbRead),
        .regaAddr    (regaAddr),
        .regbAddr    (regbAddr),
        .jCe         (jCe),
        .jAddr       (jAddr),
        .exOp        (exOp),
        .exRegaData  (exRegaData),
        .exRegbData  (exRegbData),
        .exRegcWrite (exRegcWrite),
        .exRegcAddr  (exRegcAddr)
    );

    always #2 clk = ~clk;

    function automatic logic [`WORD_W-1:0] encodeR(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`REG_ADDR_W-1:0] rt,
        input logic [`REG_ADDR_W-1:0] rd,
        input logic [`REG_ADDR_W-1:0] shamt,
        input logic [5:0]             funct
    );
        return {`OPC_RTYPE, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [`WORD_W-1:0] encodeI(
        input logic [5:0]             opcode,
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`REG_ADDR_W-1:0] rt,
        input logic [15:0]            imm
    );
        return {opcode, rs, rt, imm};
    endfunction

    function automatic logic [`WORD_W-1:0] encodeJ(
        input logic [5:0]  opcode,
        input logic [25:0] target
    );
        return {opcode, target};
    endfunction

    task automatic addRow(
        input string                  name,
        input logic [`WORD_W-1:0]     instBits,
        input logic [`WORD_W-1:0]     pcVal,
        input logic [`WORD_W-1:0]     dataA,
        input logic [`WORD_W-1:0]     dataB,
        input logic                   aRead,
        input logic                   bRead,
        input logic [`REG_ADDR_W-1:0] aAddr,
        input logic [`REG_ADDR_W-1:0] bAddr,
        input logic                   jump,
        input logic [`WORD_W-1:0]     target,
        input logic [`OP_W-1:0]       op,
        input logic [`WORD_W-1:0]     exA,
        input logic [`WORD_W-1:0]     exB,
        input logic                   cWrite,
        input logic [`REG_ADDR_W-1:0] cAddr
    );
        tableRow row;
        row = '{name, instBits, pcVal, dataA, dataB, aRead, bRead, aAddr, bAddr,
                jump, target, op, exA, exB, cWrite, cAddr};
        rows.push_back(row);
    endtask

    // name, inst, pc / register data, read enables, addresses, jump / ex outputs
    task automatic fillTable();
        addRow("ori", encodeI(`OPC_ORI, 5'd2, 5'd5, 16'h8f0f), PcBase,
               32'h1234_0000, 32'hdead_beef, 1'b1, 1'b0, 5'd2, 5'd0, 1'b0, 32'h0,
               `OP_OR, 32'h1234_0000, 32'h0000_8f0f, 1'b1, 5'd5);
        addRow("andi", encodeI(`OPC_ANDI, 5'd6, 5'd7, 16'hf00f), PcBase,
               32'hffff_ffff, 32'h0, 1'b1, 1'b0, 5'd6, 5'd0, 1'b0, 32'h0,
               `OP_AND, 32'hffff_ffff, 32'h0000_f00f, 1'b1, 5'd7);
        addRow("xori", encodeI(`OPC_XORI, 5'd8, 5'd9, 16'h8001), PcBase,
               32'h0000_00ff, 32'h0, 1'b1, 1'b0, 5'd8, 5'd0, 1'b0, 32'h0,
               `OP_XOR, 32'h0000_00ff, 32'h0000_8001, 1'b1, 5'd9);
        addRow("addi", encodeI(`OPC_ADDI, 5'd3, 5'd4, 16'hfff0), PcBase,
               32'h0000_0100, 32'h0, 1'b1, 1'b0, 5'd3, 5'd0, 1'b0, 32'h0,
               `OP_ADD, 32'h0000_0100, 32'hffff_fff0, 1'b1, 5'd4);
        addRow("subi", encodeI(`OPC_SUBI, 5'd10, 5'd11, 16'h0020), PcBase,
               32'h55, 32'h0, 1'b1, 1'b0, 5'd10, 5'd0, 1'b0, 32'h0,
               `OP_SUB, 32'h0000_0055, 32'h0000_0020, 1'b1, 5'd11);
        // no rs read, immediate on both ports
        addRow("lui", encodeI(`OPC_LUI, 5'd0, 5'd12, 16'habcd), PcBase,
               32'h1111_1111, 32'h2222_2222, 1'b0, 1'b0, 5'd0, 5'd0, 1'b0, 32'h0,
               `OP_LUI, 32'habcd_0000, 32'habcd_0000, 1'b1, 5'd12);
        addRow("add", encodeR(5'd1, 5'd2, 5'd3, 5'd0, `FN_ADD), PcBase,
               32'h11, 32'h22, 1'b1, 1'b1, 5'd1, 5'd2, 1'b0, 32'h0,
               `OP_ADD, 32'h0000_0011, 32'h0000_0022, 1'b1, 5'd3);
        addRow("sub", encodeR(5'd4, 5'd5, 5'd6, 5'd0, `FN_SUB), PcBase,
               32'h8000_0000, 32'h1, 1'b1, 1'b1, 5'd4, 5'd5, 1'b0, 32'h0,
               `OP_SUB, 32'h8000_0000, 32'h0000_0001, 1'b1, 5'd6);
        addRow("and", encodeR(5'd7, 5'd8, 5'd9, 5'd0, `FN_AND), PcBase,
               32'hf0f0_f0f0, 32'hff00_ff00, 1'b1, 1'b1, 5'd7, 5'd8, 1'b0, 32'h0,
               `OP_AND, 32'hf0f0_f0f0, 32'hff00_ff00, 1'b1, 5'd9);
        addRow("or", encodeR(5'd10, 5'd11, 5'd12, 5'd0, `FN_OR), PcBase,
               32'ha, 32'hb00, 1'b1, 1'b1, 5'd10, 5'd11, 1'b0, 32'h0,
               `OP_OR, 32'h0000_000a, 32'h0000_0b00, 1'b1, 5'd12);
        addRow("xor", encodeR(5'd13, 5'd14, 5'd15, 5'd0, `FN_XOR), PcBase,
               32'h5555_5555, 32'haaaa_aaaa, 1'b1, 1'b1, 5'd13, 5'd14, 1'b0, 32'h0,
               `OP_XOR, 32'h5555_5555, 32'haaaa_aaaa, 1'b1, 5'd15);
        addRow("add to r0", encodeR(5'd1, 5'd2, 5'd0, 5'd0, `FN_ADD), PcBase,
               32'h3, 32'h4, 1'b1, 1'b1, 5'd1, 5'd2, 1'b0, 32'h0,
               `OP_ADD, 32'h0000_0003, 32'h0000_0004, 1'b0, 5'd0);
        addRow("sll", encodeR(5'd0, 5'd16, 5'd17, 5'd4, `FN_SLL), PcBase,
               32'hffff_ffff, 32'h1, 1'b0, 1'b1, 5'd0, 5'd16, 1'b0, 32'h0,
               `OP_SLL, 32'h0000_0004, 32'h0000_0001, 1'b1, 5'd17);
        addRow("srl", encodeR(5'd0, 5'd18, 5'd19, 5'd31, `FN_SRL), PcBase,
               32'h0, 32'h8000_0000, 1'b0, 1'b1, 5'd0, 5'd18, 1'b0, 32'h0,
               `OP_SRL, 32'h0000_001f, 32'h8000_0000, 1'b1, 5'd19);
        addRow("sra", encodeR(5'd0, 5'd20, 5'd21, 5'd1, `FN_SRA), PcBase,
               32'h0, 32'hf000_0000, 1'b0, 1'b1, 5'd0, 5'd20, 1'b0, 32'h0,
               `OP_SRA, 32'h0000_0001, 32'hf000_0000, 1'b1, 5'd21);
        addRow("j", encodeJ(`OPC_J, 26'h012_3456), PcHigh,
               32'h0, 32'h0, 1'b0, 1'b0, 5'd0, 5'd0, 1'b1, 32'hb048_d158,
               `OP_J, 32'h0, 32'h0, 1'b0, 5'd0);
        addRow("jal", encodeJ(`OPC_JAL, 26'h3ff_ffff), PcEdge,
               32'h0, 32'h0, 1'b0, 1'b0, 5'd0, 5'd0, 1'b1, 32'h3fff_fffc,
               `OP_JAL, 32'h3000_0000, 32'h3000_0000, 1'b1, 5'd31);
        addRow("jr", encodeR(5'd25, 5'd0, 5'd0, 5'd0, `FN_JR), PcBase,
               32'h0040_2000, 32'h0, 1'b1, 1'b0, 5'd25, 5'd0, 1'b1, 32'h0040_2000,
               `OP_JR, 32'h0040_2000, 32'h0, 1'b0, 5'd0);
        addRow("jalr", encodeR(5'd26, 5'd0, 5'd29, 5'd0, `FN_JALR), PcBase,
               32'h0080_0010, 32'h0, 1'b1, 1'b0, 5'd26, 5'd0, 1'b1, 32'h0080_0010,
               `OP_JAL, 32'h0080_0010, 32'h0040_1004, 1'b1, 5'd29);
        addRow("beq taken", encodeI(`OPC_BEQ, 5'd1, 5'd2, 16'h0010), PcBase,
               32'h77, 32'h77, 1'b1, 1'b1, 5'd1, 5'd2, 1'b1, 32'h0040_1044,
               `OP_BEQ, 32'h0000_0077, 32'h0000_0077, 1'b0, 5'd0);
        addRow("beq not", encodeI(`OPC_BEQ, 5'd1, 5'd2, 16'h0010), PcBase,
               32'h77, 32'h78, 1'b1, 1'b1, 5'd1, 5'd2, 1'b0, 32'h0040_1044,
               `OP_BEQ, 32'h0000_0077, 32'h0000_0078, 1'b0, 5'd0);
        addRow("bne taken", encodeI(`OPC_BNE, 5'd3, 5'd4, 16'hfffe), PcBase,
               32'h5, 32'h6, 1'b1, 1'b1, 5'd3, 5'd4, 1'b1, 32'h0040_0ffc,
               `OP_BNE, 32'h0000_0005, 32'h0000_0006, 1'b0, 5'd0);
        addRow("bne not", encodeI(`OPC_BNE, 5'd3, 5'd4, 16'hfffe), PcBase,
               32'h5, 32'h5, 1'b1, 1'b1, 5'd3, 5'd4, 1'b0, 32'h0040_0ffc,
               `OP_BNE, 32'h0000_0005, 32'h0000_0005, 1'b0, 5'd0);
        addRow("bgtz taken", encodeI(`OPC_BGTZ, 5'd5, 5'd0, 16'h0100), PcBase,
               32'h1, 32'h0, 1'b1, 1'b1, 5'd5, 5'd0, 1'b1, 32'h0040_1404,
               `OP_BGTZ, 32'h0000_0001, 32'h0, 1'b0, 5'd0);
        addRow("bgtz zero", encodeI(`OPC_BGTZ, 5'd5, 5'd0, 16'h0100), PcBase,
               32'h0, 32'h0, 1'b1, 1'b1, 5'd5, 5'd0, 1'b0, 32'h0040_1404,
               `OP_BGTZ, 32'h0, 32'h0, 1'b0, 5'd0);
        addRow("bgtz neg", encodeI(`OPC_BGTZ, 5'd5, 5'd0, 16'h0100), PcBase,
               32'hffff_ffff, 32'h0, 1'b1, 1'b1, 5'd5, 5'd0, 1'b0, 32'h0040_1404,
               `OP_BGTZ, 32'hffff_ffff, 32'h0, 1'b0, 5'd0);
        addRow("bltz taken", encodeI(`OPC_BLTZ, 5'd6, 5'd0, 16'h8000), PcBase,
               32'h8000_0000, 32'h0, 1'b1, 1'b1, 5'd6, 5'd0, 1'b1, 32'h003e_1004,
               `OP_BLTZ, 32'h8000_0000, 32'h0, 1'b0, 5'd0);
        addRow("bltz not", encodeI(`OPC_BLTZ, 5'd6, 5'd0, 16'h8000), PcBase,
               32'h5, 32'h0, 1'b1, 1'b1, 5'd6, 5'd0, 1'b0, 32'h003e_1004,
               `OP_BLTZ, 32'h0000_0005, 32'h0, 1'b0, 5'd0);
        addRow("lw", encodeI(`OPC_LW, 5'd4, 5'd8, 16'hfffc), PcBase,
               32'h1000_0010, 32'h0, 1'b1, 1'b0, 5'd4, 5'd0, 1'b0, 32'h0,
               `OP_LW, 32'h1000_000c, 32'hffff_fffc, 1'b1, 5'd8);
        addRow("sw", encodeI(`OPC_SW, 5'd5, 5'd9, 16'h0008), PcBase,
               32'h2000_0000, 32'hcafe_f00d, 1'b1, 1'b1, 5'd5, 5'd9, 1'b0, 32'h0,
               `OP_SW, 32'h2000_0008, 32'hcafe_f00d, 1'b0, 5'd0);
        addRow("bad opcode", 32'hfc85_1234, PcBase,
               32'h1234, 32'h5678, 1'b0, 1'b0, 5'd0, 5'd0, 1'b0, 32'h0,
               `OP_NOP, 32'h0, 32'h0, 1'b0, 5'd0);
        addRow("bad funct", encodeR(5'd1, 5'd2, 5'd3, 5'd0, 6'h3f), PcBase,
               32'h1234, 32'h5678, 1'b0, 1'b0, 5'd0, 5'd0, 1'b0, 32'h0,
               `OP_NOP, 32'h0, 32'h0, 1'b0, 5'd0);
    endtask

    initial
    begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1 rstN = 1'b1;
    end

    initial
    begin : main
        int      errorsBefore;
        int      waitCycles;
        tableRow row;

        clk     = 1'b0;
        inst    = encodeR(5'd25, 5'd0, 5'd31, 5'd0, `FN_JALR); // jumps unless held in reset
        pc      = PcBase;
        rfDataA = 32'h0040_2000;
        rfDataB = '0;
        fillTable();

        errorsBefore = errorCount;
        waitCycles   = 0;
        while (rstN !== 1'b1 && waitCycles < ResetTimeout)
        begin
            @(negedge clk);
            waitCycles++;
            if (rstN !== 1'b1)
            begin
                checkBit("jCe", jCe, 1'b0);
                checkWord("jAddr", jAddr, '0);
                checkBit("regaRead", regaRead, 1'b0);
                checkBit("regbRead", regbRead, 1'b0);
                checkOp("exOp", exOp, `OP_NOP);
                checkBit("exRegcWrite", exRegcWrite, 1'b0);
                checkWord("exRegaData", exRegaData, '0);
                checkWord("exRegbData", exRegbData, '0);
                checkAddr("exRegcAddr", exRegcAddr, '0);
            end
        end

        if (rstN !== 1'b1)
        begin
            $display("reset was still asserted after %0d cycles, test aborted", ResetTimeout);
            $display("Simulation finished: FAIL");
        end
        else
        begin
            reportTest(errorsBefore);
            @(posedge clk);
            #1;
            // one row per cycle, ex results show up one edge later
            for (int k = 0; k < rows.size(); k++)
            begin
                row          = rows[k];
                testName     = row.name;
                errorsBefore = errorCount;
                inst         = row.instBits;
                pc           = row.pcVal;
                rfDataA      = row.dataA;
                rfDataB      = row.dataB;
                #2;
                checkBit("regaRead", regaRead, row.aRead);
                checkBit("regbRead", regbRead, row.bRead);
                checkAddr("regaAddr", regaAddr, row.aAddr);
                checkAddr("regbAddr", regbAddr, row.bAddr);
                checkBit("jCe", jCe, row.jump);
                checkWord("jAddr", jAddr, row.target);
                @(posedge clk);
                #1;
                checkOp("exOp", exOp, row.op);
                checkWord("exRegaData", exRegaData, row.exA);
                checkWord("exRegbData", exRegbData, row.exB);
                checkBit("exRegcWrite", exRegcWrite, row.cWrite);
                checkAddr("exRegcAddr", exRegcAddr, row.cAddr);
                reportTest(errorsBefore);
            end
            $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
            if (failCount == 0 && errorCount == 0)
                $display("Simulation finished: PASS");
            else
                $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* source/idStage.sv */
`include "id_defs.svh"

module idStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`WORD_W-1:0]     inst,
    input  logic [`WORD_W-1:0]     pc,
    input  logic [`WORD_W-1:0]     rfDataA,
    input  logic [`WORD_W-1:0]     rfDataB,
    output logic                   regaRead,
    output logic                   regbRead,
    output logic [`REG_ADDR_W-1:0] regaAddr,
    output logic [`REG_ADDR_W-1:0] regbAddr,
    output logic                   jCe,
    output logic [`WORD_W-1:0]     jAddr,
    output logic [`OP_W-1:0]       exOp,
    output logic [`WORD_W-1:0]     exRegaData,
    output logic [`WORD_W-1:0]     exRegbData,
    output logic                   exRegcWrite,
    output logic [`REG_ADDR_W-1:0] exRegcAddr
);

    import idPkg::*;

    instWord                instU;
    logic [`OP_W-1:0]       op;
    logic                   regcWrite;
    logic                   addrCalc;
    logic [`REG_ADDR_W-1:0] regcAddr;
    logic [`IMM_KIND_W-1:0] immKind;
    logic [`WORD_W-1:0]     linkAddr;
    logic [`WORD_W-1:0]     regaData;
    logic [`WORD_W-1:0]     regbData;

    assign instU = instWord'(inst);

    instDecoder i_instDecoder (
        .rstN      (rstN),
        .inst      (instU),
        .op        (op),
        .regaRead  (regaRead),
        .regbRead  (regbRead),
        .regcWrite (regcWrite),
        .addrCalc  (addrCalc),
        .regaAddr  (regaAddr),
        .regbAddr  (regbAddr),
        .regcAddr  (regcAddr),
        .immKind   (immKind)
    );

    operandSelect i_operandSelect (
        .addrCalc (addrCalc),
        .regaRead (regaRead),
        .regbRead (regbRead),
        .inst     (instU),
        .immKind  (immKind),
        .rfDataA  (rfDataA),
        .rfDataB  (rfDataB),
        .linkAddr (linkAddr),
        .regaData (regaData),
        .regbData (regbData)
    );

    // jumps and branches resolve here, not in EX
    branchUnit i_branchUnit (
        .rstN     (rstN),
        .inst     (instU),
        .pc       (pc),
        .rfDataA  (rfDataA),
        .rfDataB  (rfDataB),
        .linkAddr (linkAddr),
        .jAddr    (jAddr),
        .jCe      (jCe)
    );

    idExReg i_idExReg (
        .clk         (clk),
        .rstN        (rstN),
        .op          (op),
        .regaData    (regaData),
        .regbData    (regbData),
        .regcWrite   (regcWrite),
        .regcAddr    (regcAddr),
        .exOp        (exOp),
        .exRegaData  (exRegaData),
        .exRegbData  (exRegbData),
        .exRegcWrite (exRegcWrite),
        .exRegcAddr  (exRegcAddr)
    );

endmodule

/* source/idExReg.sv */
`include "id_defs.svh"

module idExReg (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`OP_W-1:0]       op,
    input  logic [`WORD_W-1:0]     regaData,
    input  logic [`WORD_W-1:0]     regbData,
    input  logic                   regcWrite,
    input  logic [`REG_ADDR_W-1:0] regcAddr,
    output logic [`OP_W-1:0]       exOp,
    output logic [`WORD_W-1:0]     exRegaData,
    output logic [`WORD_W-1:0]     exRegbData,
    output logic                   exRegcWrite,
    output logic [`REG_ADDR_W-1:0] exRegcAddr
);

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            exOp        <= `OP_NOP;
            exRegaData  <= '0;
            exRegbData  <= '0;
            exRegcWrite <= 1'b0;
            exRegcAddr  <= '0;
        end
        else
        begin
            exOp        <= op;
            exRegaData  <= regaData;
            exRegbData  <= regbData;
            exRegcWrite <= regcWrite;
            exRegcAddr  <= regcAddr;
        end
    end

    // bubble leaves reset
    resetIsBubble: assert property (
        @(posedge clk) !rstN |=> (!exRegcWrite && exOp == `OP_NOP)
    );

    // decoder drops writes to r0 before they reach EX
    noR0Write: assert property (
        @(posedge clk) disable iff (!rstN)
        exRegcWrite |-> (exRegcAddr != '0)
    );

    // a write-back always carries a real op
    wbHasOp: assert property (
        @(posedge clk) disable iff (!rstN)
        exRegcWrite |-> (exOp != `OP_NOP)
    );

endmodule

/* source/branchUnit.sv */
`include "id_defs.svh"

module branchUnit (
    input  logic               rstN,
    input  idPkg::instWord     inst,
    input  logic [`WORD_W-1:0] pc,
    input  logic [`WORD_W-1:0] rfDataA,
    input  logic [`WORD_W-1:0] rfDataB,
    output logic [`WORD_W-1:0] linkAddr,
    output logic [`WORD_W-1:0] jAddr,
    output logic               jCe
);

    localparam logic [`WORD_W-1:0] InstBytes = 4;

    logic [`WORD_W-1:0] jmpTarget;
    logic [`WORD_W-1:0] brTarget;
    logic               rsPos;

    assign linkAddr  = pc + InstBytes;
    assign jmpTarget = {linkAddr[`WORD_W-1 -: 4], inst.j.target, 2'b00};
    assign brTarget  = linkAddr + {{(`WORD_W-18){inst.i.imm[15]}}, inst.i.imm, 2'b00};
    assign rsPos     = !rfDataA[`WORD_W-1] && (rfDataA != '0); // strictly above zero

    always_comb
    begin
        jCe   = 1'b0;
        jAddr = '0;
        if (rstN)
        begin
            case (inst.r.opcode)
                `OPC_J, `OPC_JAL:
                begin
                    jCe   = 1'b1;
                    jAddr = jmpTarget;
                end
                `OPC_RTYPE:
                    if (inst.r.funct == `FN_JR || inst.r.funct == `FN_JALR)
                    begin
                        jCe   = 1'b1;
                        jAddr = rfDataA;
                    end
                `OPC_BEQ, `OPC_BNE, `OPC_BGTZ, `OPC_BLTZ:
                begin
                    jAddr = brTarget; // target shown even when not taken
                    case (inst.r.opcode)
                        `OPC_BEQ:  jCe = (rfDataA == rfDataB);
                        `OPC_BNE:  jCe = (rfDataA != rfDataB);
                        `OPC_BGTZ: jCe = rsPos;
                        default:   jCe = rfDataA[`WORD_W-1];
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

/* source/operandSelect.sv */
`include "id_defs.svh"

module operandSelect (
    input  logic                   addrCalc,
    input  logic                   regaRead,
    input  logic                   regbRead,
    input  idPkg::instWord         inst,
    input  logic [`IMM_KIND_W-1:0] immKind,
    input  logic [`WORD_W-1:0]     rfDataA,
    input  logic [`WORD_W-1:0]     rfDataB,
    input  logic [`WORD_W-1:0]     linkAddr,
    output logic [`WORD_W-1:0]     regaData,
    output logic [`WORD_W-1:0]     regbData
);

    logic [`WORD_W-1:0] imm;

    always_comb
    begin
        case (immKind)
            `IMM_ZEXT:  imm = {{(`WORD_W-16){1'b0}}, inst.i.imm};
            `IMM_SEXT:  imm = {{(`WORD_W-16){inst.i.imm[15]}}, inst.i.imm};
            `IMM_UPPER: imm = {inst.i.imm, {(`WORD_W-16){1'b0}}};
            `IMM_SHAMT: imm = {{(`WORD_W-`REG_ADDR_W){1'b0}}, inst.r.shamt};
            `IMM_LINK:  imm = linkAddr; // return address for jal / jalr
            default:    imm = '0;
        endcase
    end

    always_comb
    begin
        if (addrCalc)
            regaData = rfDataA + imm; // effective address
        else if (regaRead)
            regaData = rfDataA;
        else
            regaData = imm;
    end

    assign regbData = regbRead ? rfDataB : imm;

endmodule

/* source/instDecoder.sv */
`include "id_defs.svh"

module instDecoder (
    input  logic                   rstN,
    input  idPkg::instWord         inst,
    output logic [`OP_W-1:0]       op,
    output logic                   regaRead,
    output logic                   regbRead,
    output logic                   regcWrite,
    output logic                   addrCalc,
    output logic [`REG_ADDR_W-1:0] regaAddr,
    output logic [`REG_ADDR_W-1:0] regbAddr,
    output logic [`REG_ADDR_W-1:0] regcAddr,
    output logic [`IMM_KIND_W-1:0] immKind
);

    logic useRs;
    logic useRt;
    logic wrRt;
    logic wrRd;
    logic wrLink;

    always_comb
    begin
        op       = `OP_NOP;
        immKind  = `IMM_NONE;
        addrCalc = 1'b0;
        useRs    = 1'b0;
        useRt    = 1'b0;
        wrRt     = 1'b0;
        wrRd     = 1'b0;
        wrLink   = 1'b0;
        if (rstN)
        begin
            case (inst.r.opcode)
                `OPC_ORI, `OPC_ANDI, `OPC_XORI:
                begin
                    immKind = `IMM_ZEXT;
                    useRs   = 1'b1;
                    wrRt    = 1'b1;
                    case (inst.r.opcode)
                        `OPC_ORI:  op = `OP_OR;
                        `OPC_ANDI: op = `OP_AND;
                        default:   op = `OP_XOR;
                    endcase
                end
                `OPC_ADDI, `OPC_SUBI:
                begin
                    op      = (inst.r.opcode == `OPC_ADDI) ? `OP_ADD : `OP_SUB;
                    immKind = `IMM_SEXT;
                    useRs   = 1'b1;
                    wrRt    = 1'b1;
                end
                `OPC_LUI:
                begin
                    op      = `OP_LUI;
                    immKind = `IMM_UPPER;
                    wrRt    = 1'b1;
                end
                `OPC_RTYPE:
                    case (inst.r.funct)
                        `FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR:
                        begin
                            useRs = 1'b1;
                            useRt = 1'b1;
                            wrRd  = 1'b1;
                            case (inst.r.funct)
                                `FN_ADD: op = `OP_ADD;
                                `FN_SUB: op = `OP_SUB;
                                `FN_AND: op = `OP_AND;
                                `FN_OR:  op = `OP_OR;
                                default: op = `OP_XOR;
                            endcase
                        end
                        `FN_SLL, `FN_SRL, `FN_SRA:
                        begin
                            immKind = `IMM_SHAMT; // shift amount rides on port a
                            useRt   = 1'b1;
                            wrRd    = 1'b1;
                            case (inst.r.funct)
                                `FN_SLL: op = `OP_SLL;
                                `FN_SRL: op = `OP_SRL;
                                default: op = `OP_SRA;
                            endcase
                        end
                        `FN_JR:
                        begin
                            op    = `OP_JR;
                            useRs = 1'b1;
                        end
                        `FN_JALR:
                        begin
                            op      = `OP_JAL;
                            immKind = `IMM_LINK;
                            useRs   = 1'b1;
                            wrRd    = 1'b1;
                        end
                        default: ;
                    endcase
                `OPC_J:
                    op = `OP_J;
                `OPC_JAL:
                begin
                    op      = `OP_JAL;
                    immKind = `IMM_LINK;
                    wrLink  = 1'b1;
                end
                `OPC_BEQ, `OPC_BNE, `OPC_BGTZ, `OPC_BLTZ:
                begin
                    useRs = 1'b1;
                    useRt = 1'b1;
                    case (inst.r.opcode)
                        `OPC_BEQ:  op = `OP_BEQ;
                        `OPC_BNE:  op = `OP_BNE;
                        `OPC_BGTZ: op = `OP_BGTZ;
                        default:   op = `OP_BLTZ;
                    endcase
                end
                `OPC_LW, `OPC_SW:
                begin
                    op       = (inst.r.opcode == `OPC_LW) ? `OP_LW : `OP_SW;
                    immKind  = `IMM_SEXT;
                    addrCalc = 1'b1;
                    useRs    = 1'b1;
                    useRt    = (inst.r.opcode == `OPC_SW); // store data
                    wrRt     = (inst.r.opcode == `OPC_LW);
                end
                default: ;
            endcase
        end
    end

    assign regaRead = useRs;
    assign regbRead = useRt;
    assign regaAddr = useRs ? inst.r.rs : '0;
    assign regbAddr = useRt ? inst.r.rt : '0;

    always_comb
    begin
        if (wrLink)
            regcAddr = `LINK_REG;
        else if (wrRd)
            regcAddr = inst.r.rd;
        else if (wrRt)
            regcAddr = inst.i.rt;
        else
            regcAddr = '0;
    end

    // r0 target is a discarded write
    assign regcWrite = (wrRt || wrRd || wrLink) && (regcAddr != '0);

    // one write target at most, and only for a decoded op
    wbTargetValid: assert final (
        $onehot0({wrRt, wrRd, wrLink}) && (!(wrRt || wrRd || wrLink) || op != `OP_NOP)
    );

endmodule

/* source/idPkg.sv */
`include "id_defs.svh"

package idPkg;

    // register format
    typedef struct packed
    {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] shamt;
        logic [5:0]             funct;
    } rFields;

    // immediate format, also loads, stores and branches
    typedef struct packed
    {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } iFields;

    typedef struct packed
    {
        logic [5:0]  opcode;
        logic [25:0] target; // word index within the 256MB region
    } jFields;

    // one instruction word, three views
    typedef union packed
    {
        rFields r;
        iFields i;
        jFields j;
    } instWord;

endpackage

/* source/id_defs.svh */
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// widths
`define WORD_W      32
`define REG_ADDR_W  5
`define OP_W        6
`define IMM_KIND_W  3

`define LINK_REG    5'd31

// primary opcodes
`define OPC_RTYPE   6'b000000
`define OPC_BLTZ    6'b000001
`define OPC_J       6'b000010
`define OPC_JAL     6'b000011
`define OPC_BEQ     6'b000100
`define OPC_BNE     6'b000101
`define OPC_BGTZ    6'b000111
`define OPC_ADDI    6'b001000
`define OPC_SUBI    6'b001001
`define OPC_ANDI    6'b001100
`define OPC_ORI     6'b001101
`define OPC_XORI    6'b001110
`define OPC_LUI     6'b001111
`define OPC_LW      6'b100011
`define OPC_SW      6'b101011

// R-type function field
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_ADD      6'b100000
`define FN_SUB      6'b100010
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110

// ops handed to EX
`define OP_NOP      6'd0
`define OP_OR       6'd1
`define OP_AND      6'd2
`define OP_XOR      6'd3
`define OP_ADD      6'd4
`define OP_SUB      6'd5
`define OP_LUI      6'd6
`define OP_SLL      6'd7
`define OP_SRL      6'd8
`define OP_SRA      6'd9
`define OP_J        6'd10
`define OP_JR       6'd11
`define OP_JAL      6'd12
`define OP_BEQ      6'd13
`define OP_BNE      6'd14
`define OP_BGTZ     6'd15
`define OP_BLTZ     6'd16
`define OP_LW       6'd17
`define OP_SW       6'd18

`define IMM_NONE    3'd0
`define IMM_ZEXT    3'd1
`define IMM_SEXT    3'd2
`define IMM_UPPER   3'd3
`define IMM_SHAMT   3'd4
`define IMM_LINK    3'd5

`endif
